// File: pmp.f
pmp_pkg.sv
pmp_entry_regs.sv
pmp_addr_match.sv
pmp_perm_eval.sv
pmp_fault_resolve.sv
pmp_top.sv
pmp_chk.sv
pmp_tb.sv

// File: pmp_addr_match.sv
// ----------------------------------------------------------------------
// PMP address matcher
// Matches one request word address against every entry by its mode
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_addr_match (
  input  logic [pmp_pkg::ADDR_W-1:0]                          req_addr_i,
  input  logic [pmp_pkg::NUM_REGIONS*pmp_pkg::MODE_W-1:0]     cfg_mode_i,
  input  logic [pmp_pkg::NUM_REGIONS*pmp_pkg::PMPADDR_W-1:0]  cfg_addr_i,
  output logic [pmp_pkg::NUM_REGIONS-1:0]                     match_o
);

  // Request word address, byte offset dropped
  logic [pmp_pkg::PMPADDR_W-1:0]    req_word;

  // Per-entry unpacked view of the configuration
  pmp_pkg::pmp_mode_e               entry_mode [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::PMPADDR_W-1:0]    entry_addr [pmp_pkg::NUM_REGIONS];

  // TOR lower bound and NAPOT compare mask per entry
  logic [pmp_pkg::PMPADDR_W-1:0]    start_addr [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::PMPADDR_W-1:0]    napot_mask [pmp_pkg::NUM_REGIONS];

  // Per-mode compare results
  logic [pmp_pkg::NUM_REGIONS-1:0]  tor_hit;
  logic [pmp_pkg::NUM_REGIONS-1:0]  na4_hit;
  logic [pmp_pkg::NUM_REGIONS-1:0]  napot_hit;

  assign req_word = req_addr_i[pmp_pkg::ADDR_W-1:2];

  for (genvar r = 0; r < pmp_pkg::NUM_REGIONS; r++) begin : g_region

    // ------------------------------------------------------------------
    // Region bounds
    // ------------------------------------------------------------------

    assign entry_mode[r] =
        pmp_pkg::pmp_mode_e'(cfg_mode_i[r*pmp_pkg::MODE_W +: pmp_pkg::MODE_W]);
    assign entry_addr[r] = cfg_addr_i[r*pmp_pkg::PMPADDR_W +: pmp_pkg::PMPADDR_W];

    // Entry 0 starts its TOR range at zero
    if (r == 0) begin : g_first
      assign start_addr[r] = '0;
    end else begin : g_other
      assign start_addr[r] = entry_addr[r-1];
    end

    // Adding one flips the trailing ones and the zero above them
    // XOR marks bits 0..k, so the mask keeps only bits above k
    // All ones address gives an empty mask and matches everything
    assign napot_mask[r] = ~(entry_addr[r] ^ (entry_addr[r] + 1'b1));

    // ------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------

    // Half-open range, start inclusive and top exclusive
    assign tor_hit[r]   = (req_word >= start_addr[r]) && (req_word < entry_addr[r]);
    assign na4_hit[r]   = (req_word == entry_addr[r]);
    assign napot_hit[r] = ((req_word & napot_mask[r]) == (entry_addr[r] & napot_mask[r]));

    // Mode picks which compare counts, OFF never matches
    assign match_o[r] =
        (entry_mode[r] == pmp_pkg::PMP_MODE_TOR)   ? tor_hit[r]   :
        (entry_mode[r] == pmp_pkg::PMP_MODE_NA4)   ? na4_hit[r]   :
        (entry_mode[r] == pmp_pkg::PMP_MODE_NAPOT) ? napot_hit[r] :
                                                     1'b0;
  end

endmodule

// File: pmp_chk.sv
// ----------------------------------------------------------------------
// PMP response checker
// Handshake and reset properties of each fault resolver
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_chk (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       req_ready_o,
  input logic       rsp_valid_o,
  input logic       rsp_ready_i,
  input logic       rsp_err_o,
  input logic       rsp_hit_o,
  input logic [1:0] rsp_idx_o
);

  // Stalled answer keeps valid and payload
  held_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable({rsp_err_o, rsp_hit_o, rsp_idx_o}))
    else $error("response changed while stalled");

  // No response during reset
  reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> !rsp_valid_o)
    else $error("rsp_valid high in reset");

  // Ready only when the register is empty or drains now
  ready_rule: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_ready_o == (!rsp_valid_o || rsp_ready_i))
    else $error("req_ready breaks the empty-or-taken rule");

endmodule

bind pmp_fault_resolve pmp_chk u_chk (.*);

// File: pmp_entry_regs.sv
// ----------------------------------------------------------------------
// PMP entry register file
// Holds all entries and applies the lock rules to software writes
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_entry_regs (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  // Entry write port, always accepted
  input  logic                                                wr_en_i,
  input  logic [pmp_pkg::REGION_IDX_W-1:0]                    wr_idx_i,
  input  pmp_pkg::pmp_mode_e                                  wr_mode_i,
  input  logic                                                wr_read_i,
  input  logic                                                wr_write_i,
  input  logic                                                wr_exec_i,
  input  logic                                                wr_lock_i,
  input  logic [pmp_pkg::PMPADDR_W-1:0]                       wr_addr_i,
  // Flat per-region configuration, region 0 in the low bits
  output logic [pmp_pkg::NUM_REGIONS*pmp_pkg::MODE_W-1:0]     cfg_mode_o,
  output logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_read_o,
  output logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_write_o,
  output logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_exec_o,
  output logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_lock_o,
  output logic [pmp_pkg::NUM_REGIONS*pmp_pkg::PMPADDR_W-1:0]  cfg_addr_o
);

  // Entry state
  pmp_pkg::pmp_mode_e                 mode_q  [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::PMPADDR_W-1:0]      addr_q  [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::NUM_REGIONS-1:0]    read_q;
  logic [pmp_pkg::NUM_REGIONS-1:0]    write_q;
  logic [pmp_pkg::NUM_REGIONS-1:0]    exec_q;
  logic [pmp_pkg::NUM_REGIONS-1:0]    lock_q;

  // Address of an entry frozen by a locked TOR entry above it
  logic [pmp_pkg::NUM_REGIONS-1:0]    addr_prot;

  for (genvar r = 0; r < pmp_pkg::NUM_REGIONS; r++) begin : g_region
    // Next entry uses this address as its TOR base
    if (r < pmp_pkg::NUM_REGIONS - 1) begin : g_prot
      assign addr_prot[r] = lock_q[r+1] & (mode_q[r+1] == pmp_pkg::PMP_MODE_TOR);
    end else begin : g_last
      assign addr_prot[r] = 1'b0;
    end

    // Flatten for the checking channels
    assign cfg_mode_o[r*pmp_pkg::MODE_W +: pmp_pkg::MODE_W]       = mode_q[r];
    assign cfg_addr_o[r*pmp_pkg::PMPADDR_W +: pmp_pkg::PMPADDR_W] = addr_q[r];
  end

  assign cfg_read_o  = read_q;
  assign cfg_write_o = write_q;
  assign cfg_exec_o  = exec_q;
  assign cfg_lock_o  = lock_q;

  // --------------------------------------------------------------------
  // Write commit
  // --------------------------------------------------------------------

  // A locked entry ignores the whole write; lock only clears on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < pmp_pkg::NUM_REGIONS; r++) begin
        mode_q[r] <= pmp_pkg::PMP_MODE_OFF;
        addr_q[r] <= '0;
      end
      read_q  <= '0;
      write_q <= '0;
      exec_q  <= '0;
      lock_q  <= '0;
    end else if (wr_en_i && !lock_q[wr_idx_i]) begin
      mode_q[wr_idx_i]  <= wr_mode_i;
      read_q[wr_idx_i]  <= wr_read_i;
      write_q[wr_idx_i] <= wr_write_i;
      exec_q[wr_idx_i]  <= wr_exec_i;
      lock_q[wr_idx_i]  <= wr_lock_i;
      // Config still updates when only the address is protected
      if (!addr_prot[wr_idx_i]) begin
        addr_q[wr_idx_i] <= wr_addr_i;
      end
    end
  end

endmodule

// File: pmp_fault_resolve.sv
// ----------------------------------------------------------------------
// PMP fault resolver
// Picks the deciding entry and holds the answer in a response register
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_fault_resolve (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Request side
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  // Matcher and evaluator results
  input  logic [pmp_pkg::NUM_REGIONS-1:0]     match_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0]     allow_i,
  input  logic                                default_allow_i,
  // Response side
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output logic                                rsp_err_o,
  output logic                                rsp_hit_o,
  output logic [pmp_pkg::REGION_IDX_W-1:0]    rsp_idx_o
);

  // Combinational verdict
  logic                               hit;
  logic [pmp_pkg::REGION_IDX_W-1:0]   idx;
  logic                               err;

  // Handshake
  logic                               req_take;
  logic                               rsp_valid_q;

  // Response payload
  logic                               err_q;
  logic                               hit_q;
  logic [pmp_pkg::REGION_IDX_W-1:0]   idx_q;

  // --------------------------------------------------------------------
  // Priority select
  // --------------------------------------------------------------------

  // Scan from the top so the lowest matching entry wins
  always_comb begin
    hit = 1'b0;
    idx = '0;
    for (int r = pmp_pkg::NUM_REGIONS - 1; r >= 0; r--) begin
      if (match_i[r]) begin
        hit = 1'b1;
        idx = pmp_pkg::REGION_IDX_W'(r);
      end
    end
  end

  assign err = hit ? ~allow_i[idx] : ~default_allow_i;

  // --------------------------------------------------------------------
  // Response register
  // --------------------------------------------------------------------

  // Free when empty or emptied this cycle
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign req_take    = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_take) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Payload only moves on a new request, so a stalled answer holds
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      err_q <= err;
      hit_q <= hit;
      idx_q <= idx;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = err_q;
  assign rsp_hit_o   = hit_q;
  assign rsp_idx_o   = idx_q;

endmodule

// File: pmp_perm_eval.sv
// ----------------------------------------------------------------------
// PMP permission evaluator
// Per-entry verdict for the request type, privilege and lock bits
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_perm_eval (
  input  pmp_pkg::pmp_acc_e                 req_type_i,
  input  pmp_pkg::priv_lvl_e                req_priv_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0]   cfg_read_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0]   cfg_write_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0]   cfg_exec_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0]   cfg_lock_i,
  output logic [pmp_pkg::NUM_REGIONS-1:0]   allow_o,
  output logic                              default_allow_o
);

  // Permission bit for the requested access, one per entry
  logic [pmp_pkg::NUM_REGIONS-1:0]  perm_sel;
  logic                             is_m;

  assign is_m = (req_priv_i == pmp_pkg::PRIV_LVL_M);

  // Unused access encoding grants nothing
  always_comb begin
    case (req_type_i)
      pmp_pkg::PMP_ACC_READ:  perm_sel = cfg_read_i;
      pmp_pkg::PMP_ACC_WRITE: perm_sel = cfg_write_i;
      pmp_pkg::PMP_ACC_EXEC:  perm_sel = cfg_exec_i;
      default:                perm_sel = '0;
    endcase
  end

  // M-mode passes any unlocked entry
  // Locked entries and lower levels need the permission bit
  assign allow_o = perm_sel | ({pmp_pkg::NUM_REGIONS{is_m}} & ~cfg_lock_i);

  // No matching entry, only M-mode gets through
  assign default_allow_o = is_m;

endmodule

// File: pmp_pkg.sv
// ----------------------------------------------------------------------
// PMP shared definitions
// Widths, counts and the enums for entry mode, access type and privilege
// ----------------------------------------------------------------------
package pmp_pkg;

  // --------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------

  // Physical byte address of a request
  localparam int ADDR_W = 34;

  // Stored entry address holds byte address bits 33 to 2
  // Granule is fixed at 4 bytes, so NA4 is a legal mode
  localparam int PMPADDR_W = 32;

  // Entry count and index width
  localparam int NUM_REGIONS = 4;
  localparam int REGION_IDX_W = 2;

  // Checking channels, instruction fetch and data access
  localparam int NUM_CHAN = 2;

  // Width of one encoded entry mode
  localparam int MODE_W = 2;

  // --------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------

  // Address matching mode of an entry, RISC-V A field encoding
  typedef enum logic [MODE_W-1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_EXEC  = 2'b10
  } pmp_acc_e;

  // Privilege level of the requester
  // Value 2 is reserved, as in the ISA
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

endpackage

// File: pmp_tb.sv
// ----------------------------------------------------------------------
// PMP testbench
// Table-driven entry writes and dual-channel checks, then back-pressure
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_tb;

  // One table row, expected values packed as {err, hit, idx}
  typedef struct {
    string                          name;
    bit                             wr;
    logic [1:0]                     idx;
    pmp_pkg::pmp_mode_e             mode;
    logic [3:0]                     rwxl;
    logic [31:0]                    addr;
    logic [33:0]                    if_addr;
    pmp_pkg::pmp_acc_e              if_type;
    pmp_pkg::priv_lvl_e             if_priv;
    logic [3:0]                     if_exp;
    logic [33:0]                    dt_addr;
    pmp_pkg::pmp_acc_e              dt_type;
    pmp_pkg::priv_lvl_e             dt_priv;
    logic [3:0]                     dt_exp;
  } row_t;

  logic clk_i, rst_n_i;
  logic wr_en_i, wr_read_i, wr_write_i, wr_exec_i, wr_lock_i;
  logic [1:0] wr_idx_i;
  pmp_pkg::pmp_mode_e wr_mode_i;
  logic [31:0] wr_addr_i;
  logic if_req_valid_i, if_req_ready_o, if_rsp_valid_o, if_rsp_ready_i;
  logic if_rsp_err_o, if_rsp_hit_o;
  logic [1:0] if_rsp_idx_o;
  logic [33:0] if_req_addr_i;
  pmp_pkg::pmp_acc_e if_req_type_i;
  pmp_pkg::priv_lvl_e if_req_priv_i;
  logic dt_req_valid_i, dt_req_ready_o, dt_rsp_valid_o, dt_rsp_ready_i;
  logic dt_rsp_err_o, dt_rsp_hit_o;
  logic [1:0] dt_rsp_idx_o;
  logic [33:0] dt_req_addr_i;
  pmp_pkg::pmp_acc_e dt_req_type_i;
  pmp_pkg::priv_lvl_e dt_req_priv_i;

  row_t   rows[$];
  integer seed = 69085;
  int     row_budget = 20;
  int     wait_max = 8;
  int     stall;

  pmp_top dut0 (.*);

  always #5 clk_i = ~clk_i;

  // Packed verdicts of both channels
  wire [3:0] if_rsp = {if_rsp_err_o, if_rsp_hit_o, if_rsp_idx_o};
  wire [3:0] dt_rsp = {dt_rsp_err_o, dt_rsp_hit_o, dt_rsp_idx_o};

  task automatic check(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic give_up(input string what);
    $display("%s did not happen in time", what);
    $display("test failed");
    $fatal(1, "handshake timeout");
  endtask

  task automatic add_row(input string name, input bit wr, input logic [1:0] idx,
                         input pmp_pkg::pmp_mode_e mode, input logic [3:0] rwxl,
                         input logic [31:0] addr,
                         input logic [33:0] ia, input pmp_pkg::pmp_acc_e it,
                         input pmp_pkg::priv_lvl_e ip, input logic [3:0] ie,
                         input logic [33:0] da, input pmp_pkg::pmp_acc_e dty,
                         input pmp_pkg::priv_lvl_e dp, input logic [3:0] de);
    row_t r;
    r = '{name, wr, idx, mode, rwxl, addr, ia, it, ip, ie, da, dty, dp, de};
    rows.push_back(r);
  endtask

  // Write if needed, issue both requests, wait on handshakes, compare
  task automatic run_row(input row_t r);
    int cnt;
    if (r.wr) begin
      @(posedge clk_i);
      wr_en_i <= 1'b1;
      wr_idx_i <= r.idx;
      wr_mode_i <= r.mode;
      {wr_read_i, wr_write_i, wr_exec_i, wr_lock_i} <= r.rwxl;
      wr_addr_i <= r.addr;
      @(posedge clk_i);
      wr_en_i <= 1'b0;
    end
    @(posedge clk_i);
    if_req_valid_i <= 1'b1;
    if_req_addr_i <= r.if_addr;
    if_req_type_i <= r.if_type;
    if_req_priv_i <= r.if_priv;
    dt_req_valid_i <= 1'b1;
    dt_req_addr_i <= r.dt_addr;
    dt_req_type_i <= r.dt_type;
    dt_req_priv_i <= r.dt_priv;
    #1;
    cnt = 0;
    while (!(if_req_ready_o && dt_req_ready_o)) begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt > wait_max) give_up({r.name, " request accept"});
    end
    @(posedge clk_i);
    if_req_valid_i <= 1'b0;
    dt_req_valid_i <= 1'b0;
    #1;
    cnt = 0;
    while (!(if_rsp_valid_o && dt_rsp_valid_o)) begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt > wait_max) give_up({r.name, " response"});
    end
    check({r.name, " if"}, r.if_exp, if_rsp);
    check({r.name, " dt"}, r.dt_exp, dt_rsp);
  endtask

  // Watchdog sized from the table length
  initial begin
    #1;
    #((rows.size() * row_budget + 60) * 10);
    $display("simulation ran past its time budget");
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk_i = 0;
    rst_n_i = 0;
    {wr_en_i, wr_read_i, wr_write_i, wr_exec_i, wr_lock_i} = '0;
    wr_idx_i = '0;
    wr_mode_i = pmp_pkg::PMP_MODE_OFF;
    wr_addr_i = '0;
    {if_req_valid_i, dt_req_valid_i} = '0;
    {if_rsp_ready_i, dt_rsp_ready_i} = 2'b11;
    {if_req_addr_i, dt_req_addr_i} = '0;
    if_req_type_i = pmp_pkg::PMP_ACC_READ;
    dt_req_type_i = pmp_pkg::PMP_ACC_READ;
    if_req_priv_i = pmp_pkg::PRIV_LVL_M;
    dt_req_priv_i = pmp_pkg::PRIV_LVL_M;

    // Columns: name, write (en idx mode rwxl addr), if req + exp, dt req + exp
    add_row("reset_m", 0, 0, pmp_pkg::PMP_MODE_OFF, 4'b0000, 32'h0,
            34'h1000, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_M, 4'b0000,
            34'h2000, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_M, 4'b0000);
    add_row("reset_u", 0, 0, pmp_pkg::PMP_MODE_OFF, 4'b0000, 32'h0,
            34'h1000, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_U, 4'b1000,
            34'h2000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_U, 4'b1000);
    // TOR covers bytes 0 to 0xfff
    add_row("tor_edge", 1, 0, pmp_pkg::PMP_MODE_TOR, 4'b1010, 32'h400,
            34'hffc, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_U, 4'b0100,
            34'h1000, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b1000);
    add_row("na4_exec", 1, 1, pmp_pkg::PMP_MODE_NA4, 4'b1100, 32'h800,
            34'h2000, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_U, 4'b1101,
            34'h2004, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_U, 4'b1000);
    add_row("na4_write", 0, 0, pmp_pkg::PMP_MODE_OFF, 4'b0000, 32'h0,
            34'h1ffc, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_S, 4'b1000,
            34'h2003, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_U, 4'b0101);
    // NAPOT of 256 bytes at 0x3000
    add_row("napot_top", 1, 2, pmp_pkg::PMP_MODE_NAPOT, 4'b1000, 32'hc1f,
            34'h30fc, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b0110,
            34'h3100, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b1000);
    add_row("napot_low", 0, 0, pmp_pkg::PMP_MODE_OFF, 4'b0000, 32'h0,
            34'h2ffc, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b1000,
            34'h3000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_U, 4'b1110);
    // Entry 3 covers 64 KiB and overlaps entry 2
    add_row("overlap", 1, 3, pmp_pkg::PMP_MODE_NAPOT, 4'b1110, 32'h1fff,
            34'h3000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_U, 4'b1110,
            34'h8000, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b0111);
    add_row("m_unlocked", 0, 0, pmp_pkg::PMP_MODE_OFF, 4'b0000, 32'h0,
            34'h2000, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_M, 4'b0101,
            34'h3000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_M, 4'b0110);
    add_row("lock_m", 1, 1, pmp_pkg::PMP_MODE_NA4, 4'b1001, 32'h800,
            34'h2000, pmp_pkg::PMP_ACC_EXEC, pmp_pkg::PRIV_LVL_M, 4'b1101,
            34'h2000, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_M, 4'b0101);
    add_row("lock_ignore", 1, 1, pmp_pkg::PMP_MODE_NAPOT, 4'b1110, 32'h1fff,
            34'h2000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_M, 4'b1101,
            34'h4000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_M, 4'b0111);
    // Locked TOR from entry 2 address up to 0x4000
    add_row("tor_lock", 1, 3, pmp_pkg::PMP_MODE_TOR, 4'b1001, 32'h1000,
            34'h3f00, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b0111,
            34'h4000, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b1000);
    // Address of entry 2 must stay, its config still changes
    add_row("tor_prot", 1, 2, pmp_pkg::PMP_MODE_NAPOT, 4'b1110, 32'h0,
            34'h3000, pmp_pkg::PMP_ACC_WRITE, pmp_pkg::PRIV_LVL_U, 4'b0110,
            34'h0, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b0100)
;
    // Entry 2 off, so entry 3 TOR base at 0x307c shows on its own
    add_row("tor_base", 1, 2, pmp_pkg::PMP_MODE_OFF, 4'b0000, 32'h0,
            34'h307c, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b0111,
            34'h3078, pmp_pkg::PMP_ACC_READ, pmp_pkg::PRIV_LVL_U, 4'b1000);

    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (rows[i]) run_row(rows[i]);

    // ------------------------------------------------------------------
    // Back-pressure on the fetch channel, data keeps flowing
    // ------------------------------------------------------------------
    stall = 2 + ($unsigned($random(seed)) % 4);
    @(posedge clk_i);
    if_rsp_ready_i <= 1'b0;
    if_req_valid_i <= 1'b1;
    if_req_addr_i <= 34'h3f00;
    if_req_type_i <= pmp_pkg::PMP_ACC_READ;
    if_req_priv_i <= pmp_pkg::PRIV_LVL_U;
    dt_req_valid_i <= 1'b1;
    dt_req_addr_i <= 34'h0;
    dt_req_type_i <= pmp_pkg::PMP_ACC_READ;
    dt_req_priv_i <= pmp_pkg::PRIV_LVL_U;
    @(posedge clk_i);
    // Second fetch request waits behind the stalled one
    if_req_addr_i <= 34'h2000;
    if_req_type_i <= pmp_pkg::PMP_ACC_EXEC;
    if_req_priv_i <= pmp_pkg::PRIV_LVL_M;
    #1;
    check("bp first", 4'b0111, if_rsp);
    repeat (stall) begin
      @(posedge clk_i);
      #1;
      check("bp held valid", 4'd1, {3'b0, if_rsp_valid_o});
      check("bp held data", 4'b0111, if_rsp);
      check("bp ready low", 4'd0, {3'b0, if_req_ready_o});
      check("bp dt ready", 4'd1, {3'b0, dt_req_ready_o});
      check("bp dt valid", 4'd1, {3'b0, dt_rsp_valid_o});
      check("bp dt data", 4'b0100, dt_rsp);
    end
    @(posedge clk_i);
    if_rsp_ready_i <= 1'b1;
    @(posedge clk_i);
    if_req_valid_i <= 1'b0;
    dt_req_valid_i <= 1'b0;
    #1;
    check("bp second valid", 4'd1, {3'b0, if_rsp_valid_o});
    check("bp second", 4'b1101, if_rsp);

    $display("test passed");
    $finish;
  end

endmodule

// File: pmp_top.sv
// ----------------------------------------------------------------------
// PMP top level
// Entry registers shared by instruction fetch and data check channels
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module pmp_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Entry write port
  input  logic                               wr_en_i,
  input  logic [pmp_pkg::REGION_IDX_W-1:0]   wr_idx_i,
  input  pmp_pkg::pmp_mode_e                 wr_mode_i,
  input  logic                               wr_read_i,
  input  logic                               wr_write_i,
  input  logic                               wr_exec_i,
  input  logic                               wr_lock_i,
  input  logic [pmp_pkg::PMPADDR_W-1:0]      wr_addr_i,
  // Instruction fetch channel
  input  logic                               if_req_valid_i,
  output logic                               if_req_ready_o,
  input  logic [pmp_pkg::ADDR_W-1:0]         if_req_addr_i,
  input  pmp_pkg::pmp_acc_e                  if_req_type_i,
  input  pmp_pkg::priv_lvl_e                 if_req_priv_i,
  output logic                               if_rsp_valid_o,
  input  logic                               if_rsp_ready_i,
  output logic                               if_rsp_err_o,
  output logic                               if_rsp_hit_o,
  output logic [pmp_pkg::REGION_IDX_W-1:0]   if_rsp_idx_o,
  // Data access channel
  input  logic                               dt_req_valid_i,
  output logic                               dt_req_ready_o,
  input  logic [pmp_pkg::ADDR_W-1:0]         dt_req_addr_i,
  input  pmp_pkg::pmp_acc_e                  dt_req_type_i,
  input  pmp_pkg::priv_lvl_e                 dt_req_priv_i,
  output logic                               dt_rsp_valid_o,
  input  logic                               dt_rsp_ready_i,
  output logic                               dt_rsp_err_o,
  output logic                               dt_rsp_hit_o,
  output logic [pmp_pkg::REGION_IDX_W-1:0]   dt_rsp_idx_o
);

  // Configuration fan-out to both channels
  logic [pmp_pkg::NUM_REGIONS*pmp_pkg::MODE_W-1:0]     cfg_mode;
  logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_read;
  logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_write;
  logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_exec;
  logic [pmp_pkg::NUM_REGIONS-1:0]                     cfg_lock;
  logic [pmp_pkg::NUM_REGIONS*pmp_pkg::PMPADDR_W-1:0]  cfg_addr;

  // Per-channel results, channel 0 fetch and channel 1 data
  logic [pmp_pkg::NUM_CHAN-1:0][pmp_pkg::NUM_REGIONS-1:0]  match;
  logic [pmp_pkg::NUM_CHAN-1:0][pmp_pkg::NUM_REGIONS-1:0]  allow;
  logic [pmp_pkg::NUM_CHAN-1:0]                            default_allow;

  pmp_entry_regs u_entry_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (wr_en_i),
    .wr_idx_i   (wr_idx_i),
    .wr_mode_i  (wr_mode_i),
    .wr_read_i  (wr_read_i),
    .wr_write_i (wr_write_i),
    .wr_exec_i  (wr_exec_i),
    .wr_lock_i  (wr_lock_i),
    .wr_addr_i  (wr_addr_i),
    .cfg_mode_o (cfg_mode),
    .cfg_read_o (cfg_read),
    .cfg_write_o(cfg_write),
    .cfg_exec_o (cfg_exec),
    .cfg_lock_o (cfg_lock),
    .cfg_addr_o (cfg_addr)
  );

  // --------------------------------------------------------------------
  // Instruction fetch channel
  // --------------------------------------------------------------------

  pmp_addr_match u_if_match (
    .req_addr_i (if_req_addr_i),
    .cfg_mode_i (cfg_mode),
    .cfg_addr_i (cfg_addr),
    .match_o    (match[0])
  );

  pmp_perm_eval u_if_perm (
    .req_type_i     (if_req_type_i),
    .req_priv_i     (if_req_priv_i),
    .cfg_read_i     (cfg_read),
    .cfg_write_i    (cfg_write),
    .cfg_exec_i     (cfg_exec),
    .cfg_lock_i     (cfg_lock),
    .allow_o        (allow[0]),
    .default_allow_o(default_allow[0])
  );

  pmp_fault_resolve u_if_resolve (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (if_req_valid_i),
    .req_ready_o    (if_req_ready_o),
    .match_i        (match[0]),
    .allow_i        (allow[0]),
    .default_allow_i(default_allow[0]),
    .rsp_valid_o    (if_rsp_valid_o),
    .rsp_ready_i    (if_rsp_ready_i),
    .rsp_err_o      (if_rsp_err_o),
    .rsp_hit_o      (if_rsp_hit_o),
    .rsp_idx_o      (if_rsp_idx_o)
  );

  // --------------------------------------------------------------------
  // Data access channel
  // --------------------------------------------------------------------

  pmp_addr_match u_dt_match (
    .req_addr_i (dt_req_addr_i),
    .cfg_mode_i (cfg_mode),
    .cfg_addr_i (cfg_addr),
    .match_o    (match[1])
  );

  pmp_perm_eval u_dt_perm (
    .req_type_i     (dt_req_type_i),
    .req_priv_i     (dt_req_priv_i),
    .cfg_read_i     (cfg_read),
    .cfg_write_i    (cfg_write),
    .cfg_exec_i     (cfg_exec),
    .cfg_lock_i     (cfg_lock),
    .allow_o        (allow[1]),
    .default_allow_o(default_allow[1])
  );

  pmp_fault_resolve u_dt_resolve (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (dt_req_valid_i),
    .req_ready_o    (dt_req_ready_o),
    .match_i        (match[1]),
    .allow_i        (allow[1]),
    .default_allow_i(default_allow[1]),
    .rsp_valid_o    (dt_rsp_valid_o),
    .rsp_ready_i    (dt_rsp_ready_i),
    .rsp_err_o      (dt_rsp_err_o),
    .rsp_hit_o      (dt_rsp_hit_o),
    .rsp_idx_o      (dt_rsp_idx_o)
  );

endmodule

// File: run.sh
#!/bin/bash
# Build and run the PMP testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f pmp.f --top-module pmp_tb -o pmp_sim \
  && ./obj_dir/pmp_sim | tee sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
